// ==== build.f ====
+incdir+include
design/mac_frame_pkg.sv
design/mac_pause_pkg.sv
design/mcf_rx_filter.sv
design/lfc_rx_timer.sv
design/lfc_tx_scheduler.sv
design/mcf_tx_mux.sv
design/mac_lfc.sv
testbench/mac_lfc_assertions.sv
testbench/tb_mac_lfc.sv

// ==== Bender.yml ====
package:
  name: mac_lfc

sources:
  - include_dirs:
      - include
    files:
      - design/mac_frame_pkg.sv
      - design/mac_pause_pkg.sv
      - design/mcf_rx_filter.sv
      - design/lfc_rx_timer.sv
      - design/lfc_tx_scheduler.sv
      - design/mcf_tx_mux.sv
      - design/mac_lfc.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/mac_lfc_assertions.sv
      - testbench/tb_mac_lfc.sv

// ==== testbench/tb_mac_lfc.sv ====
// table driven testbench for mac_lfc, run as top module tb_mac_lfc with the bound assertions
`include "mac_lfc_params.svh"

module tb_mac_lfc
    import mac_frame_pkg::*, mac_pause_pkg::*;
;

    localparam int A_RX_DATA = 0;
    localparam int A_RX_MCF  = 1;
    localparam int A_TX_DATA = 2;
    localparam int A_LFC_LVL = 3;
    localparam int A_TX_MIX  = 4;
    localparam int A_PAUSE   = 5;
    localparam logic [47:0] REMOTE_SRC = 48'h02_11_22_33_44_55;
    localparam quanta_t     CFG_QUANTA = 16'h0123;

    logic clk, rst_n;
    logic rx_in_valid, rx_in_last, rx_out_valid, rx_out_last;
    data_t rx_in_data, rx_out_data, tx_in_data, tx_out_data;
    keep_t rx_in_keep, rx_out_keep, tx_in_keep, tx_out_keep;
    logic tx_in_valid, tx_in_ready, tx_in_last, tx_out_valid, tx_out_ready, tx_out_last;
    logic rx_lfc_en, rx_lfc_req, tx_lfc_req, tx_lfc_resend;
    quanta_t cfg_tx_lfc_quanta, cfg_tx_lfc_refresh;
    logic tx_pause_req, tx_lfc_pause_en, tx_pause_ack;
    logic stat_rx_lfc_pkt, stat_rx_lfc_xon, stat_rx_lfc_xoff;
    logic stat_tx_lfc_pkt, stat_tx_lfc_xon, stat_tx_lfc_xoff;

    string t_name[$];
    int    t_act[$], t_arg[$], t_op[$], t_en[$], t_exp[$];

    logic [72:0] rx_src[$], rx_q[$], tx_src[$], tx_exp[$], tx_q[$];   // {last, keep, data}
    time   drv_t[$], rx_t[$];
    int    errors, timeouts;
    int    rx_pkt, rx_xoff, rx_xon, req_cycles, tx_pkt, tx_xoff, tx_xon, paused_beats;

    mac_lfc u_mac_lfc (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        if (!rst_n) tx_out_ready <= 1'b0;
        else tx_out_ready <= ($urandom % 4) != 0;   // roughly one stall in four
    end

    // outputs are sampled away from the active edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (rx_out_valid) begin
                rx_q.push_back({rx_out_last, rx_out_keep, rx_out_data});
                rx_t.push_back($time);
            end
            if (tx_out_valid && tx_out_ready) begin
                tx_q.push_back({tx_out_last, tx_out_keep, tx_out_data});
                if (rx_lfc_req && tx_lfc_pause_en) paused_beats++;
            end
            if (rx_lfc_req) req_cycles++;
            if (stat_rx_lfc_pkt) rx_pkt++;
            if (stat_rx_lfc_xoff) rx_xoff++;
            if (stat_rx_lfc_xon) rx_xon++;
            if (stat_tx_lfc_pkt) tx_pkt++;
            if (stat_tx_lfc_xoff) tx_xoff++;
            if (stat_tx_lfc_xon) tx_xon++;
        end
    end

    task automatic report_value(string name, logic [72:0] exp, logic [72:0] act);
        errors++;
        $display("Fail %s: expected %h, actual %h", name, exp, act);
    endtask

    task automatic report_timeout(string what);
        timeouts++;
        $display("Timeout while waiting for %s", what);
    endtask

    task automatic add_row(string name, int act, int arg, int op, int en, int exp);
        t_name.push_back(name);
        t_act.push_back(act);
        t_arg.push_back(arg);
        t_op.push_back(op);
        t_en.push_back(en);
        t_exp.push_back(exp);
    endtask

    // expected rx_lfc_req length is quanta x 8 cycles when accepted
    task automatic fill_table();
        add_row("rx_data_5",   A_RX_DATA, 5, 0, 1, 0);
        add_row("rx_data_1",   A_RX_DATA, 1, 0, 1, 0);
        add_row("rx_xoff_q3",  A_RX_MCF,  3, 1, 1, 24);
        add_row("rx_xon_q0",   A_RX_MCF,  0, 1, 1, 0);
        add_row("rx_xoff_dis", A_RX_MCF,  5, 1, 0, 0);
        add_row("rx_other_op", A_RX_MCF,  5, 2, 1, 0);
        add_row("tx_data_7",   A_TX_DATA, 7, 0, 0, 0);
        add_row("lfc_xoff",    A_LFC_LVL, 1, 0, 0, CFG_QUANTA);
        add_row("lfc_refresh", A_LFC_LVL, 1, 0, 0, CFG_QUANTA);
        add_row("lfc_xon",     A_LFC_LVL, 0, 0, 0, 0);
        add_row("tx_mix",      A_TX_MIX,  6, 0, 0, CFG_QUANTA);
        add_row("lfc_xon_mix", A_LFC_LVL, 0, 0, 0, 0);
        add_row("pause_q4",    A_PAUSE,   4, 1, 1, 0);
    endtask

    // control frame built byte by byte from the annex 31B layout
    function automatic data_t mcf_beat(logic [47:0] src, logic [15:0] op, logic [15:0] q,
                                       int idx);
        logic [7:0]  b [0:23];
        logic [47:0] dst;
        logic [15:0] et;
        data_t       d;
        dst = `MCF_DST_MCAST;
        et  = `MCF_ETH_TYPE;
        for (int k = 0; k < 6; k++) begin
            b[k]     = dst[47-8*k -: 8];
            b[6 + k] = src[47-8*k -: 8];
        end
        b[12] = et[15:8];
        b[13] = et[7:0];
        b[14] = op[15:8];
        b[15] = op[7:0];
        b[16] = q[15:8];
        b[17] = q[7:0];
        for (int k = 18; k < 24; k++) b[k] = 8'h00;
        for (int k = 0; k < 8; k++) d[8*k +: 8] = b[idx*8 + k];
        return d;
    endfunction

    task automatic push_mcf_exp(logic [15:0] q);
        for (int k = 0; k < 3; k++) begin
            tx_exp.push_back({k == 2, 8'hff, mcf_beat(`LFC_SRC_ADDR, 16'h0001, q, k)});
        end
    endtask

    task automatic make_tx_frame(int n);
        logic [72:0] b;
        for (int k = 0; k < n; k++) begin
            b = {k == n - 1, (k == n - 1) ? 8'h07 : 8'hff, $urandom, $urandom};
            tx_src.push_back(b);
            tx_exp.push_back(b);
        end
    endtask

    task automatic drive_rx();
        for (int k = 0; k < rx_src.size(); k++) begin
            @(posedge clk);
            rx_in_valid <= 1'b1;
            rx_in_data  <= rx_src[k][63:0];
            rx_in_keep  <= rx_src[k][71:64];
            rx_in_last  <= rx_src[k][72];
            drv_t.push_back($time);
        end
        @(posedge clk);
        rx_in_valid <= 1'b0;
        rx_in_last  <= 1'b0;
    endtask

    task automatic drive_tx();
        int t;
        for (int k = 0; k < tx_src.size(); k++) begin
            @(posedge clk);
            tx_in_valid <= 1'b1;
            tx_in_data  <= tx_src[k][63:0];
            tx_in_keep  <= tx_src[k][71:64];
            tx_in_last  <= tx_src[k][72];
            t = 0;
            do begin
                @(negedge clk);
                t++;
            end while (!tx_in_ready && t < 400);
            if (!tx_in_ready) report_timeout("tx_in_ready");
        end
        @(posedge clk);
        tx_in_valid <= 1'b0;
        tx_in_last  <= 1'b0;
        tx_src.delete();
    endtask

    task automatic compare_tx(string name);
        int t;
        logic [72:0] a, e;
        t = 0;
        while (tx_q.size() < tx_exp.size() && t < 600) begin
            @(posedge clk);
            t++;
        end
        if (tx_q.size() < tx_exp.size()) report_timeout({name, " tx_out beats"});
        while (tx_exp.size() > 0 && tx_q.size() > 0) begin
            e = tx_exp.pop_front();
            a = tx_q.pop_front();
            if (a !== e) report_value(name, e, a);
        end
        tx_exp.delete();
    endtask

    task automatic do_rx_data(int i);
        int t;
        logic [72:0] a;
        time at;
        rx_src.delete();
        drv_t.delete();
        for (int k = 0; k < t_arg[i]; k++) begin
            rx_src.push_back({k == t_arg[i] - 1, (k == t_arg[i] - 1) ? 8'h3f : 8'hff,
                              $urandom, $urandom});
        end
        drive_rx();
        t = 0;
        while (rx_q.size() < rx_src.size() && t < 50) begin
            @(posedge clk);
            t++;
        end
        if (rx_q.size() < rx_src.size()) report_timeout({t_name[i], " rx_out beats"});
        for (int k = 0; k < rx_src.size() && rx_q.size() > 0; k++) begin
            a  = rx_q.pop_front();
            at = rx_t.pop_front();
            if (a !== rx_src[k]) report_value(t_name[i], rx_src[k], a);
            if (at - drv_t[k] != 25) report_value({t_name[i], "_latency"}, 25, at - drv_t[k]);
        end
    endtask

    task automatic do_rx_mcf(int i);
        int t;
        int exp_pkt;
        exp_pkt = (t_op[i] == 1) && (t_en[i] != 0);
        @(posedge clk);
        rx_lfc_en <= (t_en[i] != 0);
        rx_pkt = 0;
        rx_xoff = 0;
        rx_xon = 0;
        req_cycles = 0;
        rx_src.delete();
        for (int k = 0; k < 3; k++) begin
            rx_src.push_back({k == 2, 8'hff, mcf_beat(REMOTE_SRC, t_op[i], t_arg[i], k)});
        end
        drive_rx();
        t = 0;
        while (rx_pkt == 0 && t < 20) begin   // observation window, no pulse is fine here
            @(negedge clk);
            t++;
        end
        t = 0;
        while (rx_lfc_req && t < 2000) begin
            @(negedge clk);
            t++;
        end
        if (rx_lfc_req) report_timeout({t_name[i], " rx_lfc_req release"});
        @(negedge clk);
        if (req_cycles != t_exp[i]) report_value({t_name[i], "_req"}, t_exp[i], req_cycles);
        if (rx_pkt != exp_pkt) report_value({t_name[i], "_pkt"}, exp_pkt, rx_pkt);
        if (rx_xoff != (exp_pkt && t_arg[i] != 0))
            report_value({t_name[i], "_xoff"}, exp_pkt && t_arg[i] != 0, rx_xoff);
        if (rx_xon != (exp_pkt && t_arg[i] == 0))
            report_value({t_name[i], "_xon"}, exp_pkt && t_arg[i] == 0, rx_xon);
        if (rx_q.size() != 0) begin
            errors++;
            $display("%s: a control frame showed up on rx_out", t_name[i]);
            rx_q.delete();
            rx_t.delete();
        end
    endtask

    task automatic do_lfc_level(int i);
        @(posedge clk);
        tx_lfc_req <= (t_arg[i] != 0);
        tx_pkt = 0;
        tx_xoff = 0;
        tx_xon = 0;
        push_mcf_exp(t_exp[i]);
        compare_tx(t_name[i]);
        if (tx_pkt != 1) report_value({t_name[i], "_pkt"}, 1, tx_pkt);
        if (tx_xoff != (t_arg[i] != 0)) report_value({t_name[i], "_xoff"}, t_arg[i], tx_xoff);
        if (tx_xon != (t_arg[i] == 0)) report_value({t_name[i], "_xon"}, !t_arg[i], tx_xon);
    endtask

    task automatic do_tx_mix(int i);
        make_tx_frame(t_arg[i]);
        push_mcf_exp(t_exp[i]);                // XOFF must wait for the frame end
        fork
            drive_tx();
            begin
                repeat (3) @(posedge clk);
                tx_lfc_req <= 1'b1;
            end
        join
        compare_tx(t_name[i]);
    endtask

    task automatic do_pause(int i);
        int t;
        @(posedge clk);
        rx_lfc_en       <= 1'b1;
        tx_lfc_pause_en <= 1'b1;
        rx_pkt = 0;
        paused_beats = 0;
        rx_src.delete();
        for (int k = 0; k < 3; k++) begin
            rx_src.push_back({k == 2, 8'hff, mcf_beat(REMOTE_SRC, t_op[i], t_arg[i], k)});
        end
        drive_rx();
        t = 0;
        while (rx_pkt == 0 && t < 20) begin
            @(negedge clk);
            t++;
        end
        if (rx_pkt == 0) report_timeout({t_name[i], " stat_rx_lfc_pkt"});
        @(negedge clk);
        if (tx_pause_ack !== 1'b1) report_value({t_name[i], "_ack"}, 1, tx_pause_ack);
        make_tx_frame(4);
        drive_tx();
        compare_tx(t_name[i]);
        if (paused_beats != 0) report_value({t_name[i], "_held"}, 0, paused_beats);
        tx_lfc_pause_en <= 1'b0;
    endtask

    initial begin
        void'($urandom(88));
        errors = 0;
        timeouts = 0;
        rst_n = 1'b0;
        rx_in_valid = 1'b0;
        rx_in_data = '0;
        rx_in_keep = '0;
        rx_in_last = 1'b0;
        tx_in_valid = 1'b0;
        tx_in_data = '0;
        tx_in_keep = '0;
        tx_in_last = 1'b0;
        tx_out_ready = 1'b0;
        rx_lfc_en = 1'b1;
        tx_lfc_req = 1'b0;
        tx_lfc_resend = 1'b0;
        cfg_tx_lfc_quanta = CFG_QUANTA;
        cfg_tx_lfc_refresh = 16'd4;     // 32 cycles between XOFF repeats
        tx_pause_req = 1'b0;
        tx_lfc_pause_en = 1'b0;
        fill_table();
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        if ({rx_out_valid, tx_out_valid, tx_in_ready, rx_lfc_req, tx_pause_ack,
             stat_rx_lfc_pkt, stat_rx_lfc_xon, stat_rx_lfc_xoff,
             stat_tx_lfc_pkt, stat_tx_lfc_xon, stat_tx_lfc_xoff} !== '0) begin
            errors++;
            $display("outputs not low after reset");
        end
        for (int i = 0; i < t_name.size(); i++) begin
            case (t_act[i])
                A_RX_DATA: do_rx_data(i);
                A_RX_MCF:  do_rx_mcf(i);
                A_TX_DATA: begin
                    make_tx_frame(t_arg[i]);
                    drive_tx();
                    compare_tx(t_name[i]);
                end
                A_LFC_LVL: do_lfc_level(i);
                A_TX_MIX:  do_tx_mix(i);
                default:   do_pause(i);
            endcase
        end
        repeat (5) @(posedge clk);
        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== testbench/mac_lfc_assertions.sv ====
// stream protocol and pause checks, bound into every mac_lfc instance by the bind below
module mac_lfc_assertions
    import mac_frame_pkg::*;
(
    input logic  clk,
    input logic  rst_n,
    input logic  tx_in_ready,
    input logic  tx_out_valid,
    input logic  tx_out_ready,
    input data_t tx_out_data,
    input keep_t tx_out_keep,
    input logic  tx_out_last,
    input logic  rx_lfc_en,
    input logic  stat_rx_lfc_pkt,
    input logic  tx_pause_ack
);

    // a stalled beat must not change until it is taken
    tx_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        tx_out_valid && !tx_out_ready |=> tx_out_valid && $stable(tx_out_data)
            && $stable(tx_out_keep) && $stable(tx_out_last))
        else $error("tx_out beat changed under back-pressure");

    // a frame seen while disabled must not load the timer
    rx_load_gated: assert property (@(posedge clk) disable iff (!rst_n)
        !rx_lfc_en |=> !stat_rx_lfc_pkt)
        else $error("pause timer loaded with rx_lfc_en low");

    // ack means idle and paused, so the next beat out is no user data
    no_start_paused: assert property (@(posedge clk) disable iff (!rst_n)
        tx_pause_ack |=> !(tx_out_valid && tx_in_ready))
        else $error("tx_out frame started while pause acknowledged");

endmodule

bind mac_lfc mac_lfc_assertions u_mac_lfc_assertions (.*);

// ==== design/mac_lfc.sv ====
// link-level flow control layer of the 64-bit MAC, placed between user streams and MAC core
module mac_lfc
    import mac_frame_pkg::*, mac_pause_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    rx_in_valid,
    input  data_t   rx_in_data,
    input  keep_t   rx_in_keep,
    input  logic    rx_in_last,
    output logic    rx_out_valid,
    output data_t   rx_out_data,
    output keep_t   rx_out_keep,
    output logic    rx_out_last,
    input  logic    tx_in_valid,
    output logic    tx_in_ready,
    input  data_t   tx_in_data,
    input  keep_t   tx_in_keep,
    input  logic    tx_in_last,
    output logic    tx_out_valid,
    input  logic    tx_out_ready,
    output data_t   tx_out_data,
    output keep_t   tx_out_keep,
    output logic    tx_out_last,
    input  logic    rx_lfc_en,
    output logic    rx_lfc_req,
    input  logic    tx_lfc_req,
    input  logic    tx_lfc_resend,
    input  quanta_t cfg_tx_lfc_quanta,
    input  quanta_t cfg_tx_lfc_refresh,
    input  logic    tx_pause_req,
    input  logic    tx_lfc_pause_en,
    output logic    tx_pause_ack,
    output logic    stat_rx_lfc_pkt,
    output logic    stat_rx_lfc_xon,
    output logic    stat_rx_lfc_xoff,
    output logic    stat_tx_lfc_pkt,
    output logic    stat_tx_lfc_xon,
    output logic    stat_tx_lfc_xoff
);

    logic    mcf_lfc_valid;
    quanta_t mcf_quanta;
    logic    lfc_valid;
    logic    lfc_ready;
    quanta_t lfc_quanta;

    mcf_rx_filter u_mcf_rx_filter (
        .clk           (clk),
        .rst_n         (rst_n),
        .rx_in_valid   (rx_in_valid),
        .rx_in_data    (rx_in_data),
        .rx_in_keep    (rx_in_keep),
        .rx_in_last    (rx_in_last),
        .rx_out_valid  (rx_out_valid),
        .rx_out_data   (rx_out_data),
        .rx_out_keep   (rx_out_keep),
        .rx_out_last   (rx_out_last),
        .mcf_lfc_valid (mcf_lfc_valid),
        .mcf_quanta    (mcf_quanta)
    );

    lfc_rx_timer u_lfc_rx_timer (
        .clk              (clk),
        .rst_n            (rst_n),
        .mcf_lfc_valid    (mcf_lfc_valid),
        .mcf_quanta       (mcf_quanta),
        .rx_lfc_en        (rx_lfc_en),
        .rx_lfc_req       (rx_lfc_req),
        .stat_rx_lfc_pkt  (stat_rx_lfc_pkt),
        .stat_rx_lfc_xon  (stat_rx_lfc_xon),
        .stat_rx_lfc_xoff (stat_rx_lfc_xoff)
    );

    lfc_tx_scheduler u_lfc_tx_scheduler (
        .clk                (clk),
        .rst_n              (rst_n),
        .tx_lfc_req         (tx_lfc_req),
        .tx_lfc_resend      (tx_lfc_resend),
        .cfg_tx_lfc_quanta  (cfg_tx_lfc_quanta),
        .cfg_tx_lfc_refresh (cfg_tx_lfc_refresh),
        .lfc_ready          (lfc_ready),
        .lfc_valid          (lfc_valid),
        .lfc_quanta         (lfc_quanta),
        .stat_tx_lfc_pkt    (stat_tx_lfc_pkt),
        .stat_tx_lfc_xon    (stat_tx_lfc_xon),
        .stat_tx_lfc_xoff   (stat_tx_lfc_xoff)
    );

    // remote pause comes straight from the rx timer, same clock
    mcf_tx_mux u_mcf_tx_mux (
        .clk             (clk),
        .rst_n           (rst_n),
        .tx_in_valid     (tx_in_valid),
        .tx_in_data      (tx_in_data),
        .tx_in_keep      (tx_in_keep),
        .tx_in_last      (tx_in_last),
        .tx_out_ready    (tx_out_ready),
        .lfc_valid       (lfc_valid),
        .lfc_quanta      (lfc_quanta),
        .tx_pause_req    (tx_pause_req),
        .tx_lfc_pause_en (tx_lfc_pause_en),
        .rx_lfc_req      (rx_lfc_req),
        .tx_in_ready     (tx_in_ready),
        .tx_out_valid    (tx_out_valid),
        .tx_out_data     (tx_out_data),
        .tx_out_keep     (tx_out_keep),
        .tx_out_last     (tx_out_last),
        .lfc_ready       (lfc_ready),
        .tx_pause_ack    (tx_pause_ack)
    );

endmodule

// ==== design/mcf_tx_mux.sv ====
// merges generated PAUSE frames into the tx stream between frames and holds data while paused
`include "mac_lfc_params.svh"

module mcf_tx_mux
    import mac_frame_pkg::*, mac_pause_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    tx_in_valid,
    input  data_t   tx_in_data,
    input  keep_t   tx_in_keep,
    input  logic    tx_in_last,
    input  logic    tx_out_ready,
    input  logic    lfc_valid,
    input  quanta_t lfc_quanta,
    input  logic    tx_pause_req,
    input  logic    tx_lfc_pause_en,
    input  logic    rx_lfc_req,
    output logic    tx_in_ready,
    output logic    tx_out_valid,
    output data_t   tx_out_data,
    output keep_t   tx_out_keep,
    output logic    tx_out_last,
    output logic    lfc_ready,
    output logic    tx_pause_ack
);

    localparam mac_addr_t   DST_ADDR = `MCF_DST_MCAST;
    localparam mac_addr_t   SRC_ADDR = `LFC_SRC_ADDR;
    localparam logic [15:0] ETH_TYPE = `MCF_ETH_TYPE;
    localparam logic [15:0] OPCODE   = mcf_op_lfc;

    tx_mux_state_e state;
    quanta_t       quanta_q;
    logic          paused;
    data_t         beat0;
    data_t         beat1;
    data_t         beat2;

    assign paused       = tx_pause_req || (tx_lfc_pause_en && rx_lfc_req);
    assign tx_pause_ack = paused && (state == tx_idle);
    assign lfc_ready    = (state == tx_idle);

    always_comb begin
        beat0[47:0]  = {<<8{DST_ADDR}};
        beat0[63:48] = {<<8{SRC_ADDR[47:32]}};     // src bytes 0-1
        beat1[31:0]  = {<<8{SRC_ADDR[31:0]}};
        beat1[47:32] = {<<8{ETH_TYPE}};
        beat1[63:48] = {<<8{OPCODE}};
        beat2[15:0]  = {<<8{quanta_q}};
        beat2[63:16] = '0;
    end

    always_comb begin
        tx_out_valid = 1'b0;
        tx_in_ready  = 1'b0;
        tx_out_data  = tx_in_data;
        tx_out_keep  = tx_in_keep;
        tx_out_last  = tx_in_last;
        case (state)
            tx_data: begin
                tx_out_valid = tx_in_valid;
                tx_in_ready  = tx_out_ready;
            end
            tx_mcf_hdr0: begin
                tx_out_valid = 1'b1;
                tx_out_data  = beat0;
                tx_out_keep  = '1;
                tx_out_last  = 1'b0;
            end
            tx_mcf_hdr1: begin
                tx_out_valid = 1'b1;
                tx_out_data  = beat1;
                tx_out_keep  = '1;
                tx_out_last  = 1'b0;
            end
            tx_mcf_params: begin
                tx_out_valid = 1'b1;
                tx_out_data  = beat2;
                tx_out_keep  = '1;
                tx_out_last  = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= tx_idle;
        end else begin
            case (state)
                tx_idle: begin
                    if (lfc_valid) state <= tx_mcf_hdr0;   // control frame beats waiting data
                    else if (tx_in_valid && !paused) state <= tx_data;
                end
                tx_data: begin
                    if (tx_in_valid && tx_out_ready && tx_in_last) state <= tx_idle;
                end
                tx_mcf_hdr0: begin
                    if (tx_out_ready) state <= tx_mcf_hdr1;
                end
                tx_mcf_hdr1: begin
                    if (tx_out_ready) state <= tx_mcf_params;
                end
                default: begin
                    if (tx_out_ready) state <= tx_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (lfc_valid && lfc_ready) begin
            quanta_q <= lfc_quanta;
        end
    end

endmodule

// ==== design/lfc_tx_scheduler.sv ====
// turns the local pause request level into XOFF and XON requests for the tx mux
`include "mac_lfc_params.svh"

module lfc_tx_scheduler
    import mac_pause_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    tx_lfc_req,
    input  logic    tx_lfc_resend,
    input  quanta_t cfg_tx_lfc_quanta,
    input  quanta_t cfg_tx_lfc_refresh,
    input  logic    lfc_ready,
    output logic    lfc_valid,
    output quanta_t lfc_quanta,
    output logic    stat_tx_lfc_pkt,
    output logic    stat_tx_lfc_xon,
    output logic    stat_tx_lfc_xoff
);

    localparam pause_timer_t STEP = pause_timer_t'(`QUANTA_STEP);

    lfc_event_e   pend_q;
    pause_timer_t elapsed_q;    // time since last transfer
    quanta_t      elapsed_quanta;
    logic         req_q;
    logic         rise;
    logic         fall;
    logic         xfer;
    logic         refresh_due;
    logic         want_xoff;

    assign elapsed_quanta = elapsed_q[`QUANTA_FRAC_W +: $bits(quanta_t)];
    assign rise        = tx_lfc_req && !req_q;
    assign fall        = !tx_lfc_req && req_q;
    assign lfc_valid   = (pend_q != ev_none);
    assign xfer        = lfc_valid && lfc_ready;
    assign refresh_due = tx_lfc_req && (pend_q == ev_none)
                         && (elapsed_quanta >= cfg_tx_lfc_refresh);
    assign want_xoff   = rise || (tx_lfc_req && tx_lfc_resend) || refresh_due;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_q            <= 1'b0;
            pend_q           <= ev_none;
            elapsed_q        <= '0;
            stat_tx_lfc_pkt  <= 1'b0;
            stat_tx_lfc_xon  <= 1'b0;
            stat_tx_lfc_xoff <= 1'b0;
        end else begin
            req_q            <= tx_lfc_req;
            stat_tx_lfc_pkt  <= xfer;
            stat_tx_lfc_xon  <= xfer && (pend_q == ev_xon);
            stat_tx_lfc_xoff <= xfer && (pend_q == ev_xoff);
            if (fall) pend_q <= ev_xon;             // replaces anything not yet taken
            else if (want_xoff) pend_q <= ev_xoff;
            else if (xfer) pend_q <= ev_none;
            if (xfer) begin
                elapsed_q <= '0;
            end else if (elapsed_quanta != '1) begin
                elapsed_q <= elapsed_q + STEP;      // saturates past any refresh value
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fall) begin
            lfc_quanta <= '0;
        end else if (want_xoff) begin
            lfc_quanta <= cfg_tx_lfc_quanta;
        end
    end

endmodule

// ==== design/lfc_rx_timer.sv ====
// pause timer loaded from received LFC frames, drives rx_lfc_req and the rx pause stats
`include "mac_lfc_params.svh"

module lfc_rx_timer
    import mac_pause_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    mcf_lfc_valid,
    input  quanta_t mcf_quanta,
    input  logic    rx_lfc_en,
    output logic    rx_lfc_req,
    output logic    stat_rx_lfc_pkt,
    output logic    stat_rx_lfc_xon,
    output logic    stat_rx_lfc_xoff
);

    localparam pause_timer_t STEP = pause_timer_t'(`QUANTA_STEP);

    pause_timer_t timer_q;
    pause_timer_t load_val;
    logic         load;

    assign load     = mcf_lfc_valid && rx_lfc_en;
    assign load_val = pause_timer_t'(mcf_quanta) << `QUANTA_FRAC_W;   // quanta x 256

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            timer_q          <= '0;
            stat_rx_lfc_pkt  <= 1'b0;
            stat_rx_lfc_xon  <= 1'b0;
            stat_rx_lfc_xoff <= 1'b0;
        end else begin
            stat_rx_lfc_pkt  <= load;
            stat_rx_lfc_xon  <= load && (mcf_quanta == '0);
            stat_rx_lfc_xoff <= load && (mcf_quanta != '0);
            if (load) begin
                timer_q <= load_val;            // newest frame wins, zero quanta is XON
            end else if (timer_q > STEP) begin
                timer_q <= timer_q - STEP;
            end else begin
                timer_q <= '0;
            end
        end
    end

    // eight clocks per quantum at 64 bits per cycle
    assign rx_lfc_req = (timer_q != '0) && rx_lfc_en;

endmodule

// ==== design/mcf_rx_filter.sv ====
// receive side delay line that strips MAC control frames and reports LFC quanta to the timer
`include "mac_lfc_params.svh"

module mcf_rx_filter
    import mac_frame_pkg::*, mac_pause_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    rx_in_valid,
    input  data_t   rx_in_data,
    input  keep_t   rx_in_keep,
    input  logic    rx_in_last,
    output logic    rx_out_valid,
    output data_t   rx_out_data,
    output keep_t   rx_out_keep,
    output logic    rx_out_last,
    output logic    mcf_lfc_valid,
    output quanta_t mcf_quanta
);

    rx_filt_state_e state;
    mcf_opcode_e    opcode_q;       // latched from beat 1
    mcf_opcode_e    in_opcode;
    logic [15:0]    in_opcode_raw;
    logic [15:0]    eth_type;
    mac_addr_t      dst_addr;
    logic           is_mcf;
    logic           in_drop;
    logic           frame_end;

    logic  s1_valid;
    logic  s1_drop;
    data_t s1_data;
    keep_t s1_keep;
    logic  s1_last;
    logic  s2_valid;
    logic  s2_drop;
    data_t s2_data;
    keep_t s2_keep;
    logic  s2_last;

    always_comb begin
        dst_addr      = {<<8{s1_data[47:0]}};      // beat 0 is in stage 1 by now
        eth_type      = {<<8{rx_in_data[47:32]}};
        in_opcode_raw = {<<8{rx_in_data[63:48]}};
        in_opcode     = (in_opcode_raw == mcf_op_lfc) ? mcf_op_lfc : mcf_op_other;
        is_mcf        = (dst_addr == `MCF_DST_MCAST) && (eth_type == `MCF_ETH_TYPE);
        frame_end     = rx_in_valid && rx_in_last;
        case (state)
            rx_hdr1:            in_drop = is_mcf;
            rx_params, rx_drop: in_drop = 1'b1;
            default:            in_drop = 1'b0;    // beat 0, fixed up one stage later
        endcase
    end

    always_ff @(posedge clk) begin
        s1_data <= rx_in_data;
        s1_keep <= rx_in_keep;
        s1_last <= rx_in_last;
        s2_data <= s1_data;
        s2_keep <= s1_keep;
        s2_last <= s1_last;
        if (state == rx_params && rx_in_valid) begin
            mcf_quanta <= {<<8{rx_in_data[15:0]}};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid      <= 1'b0;
            s1_drop       <= 1'b0;
            s2_valid      <= 1'b0;
            s2_drop       <= 1'b0;
            state         <= rx_hdr0;
            opcode_q      <= mcf_op_other;
            mcf_lfc_valid <= 1'b0;
        end else begin
            s1_valid <= rx_in_valid;
            s1_drop  <= in_drop;
            s2_valid <= s1_valid;
            // beat 0 learns its fate while beat 1 is at the input
            s2_drop  <= (state == rx_hdr1 && rx_in_valid) ? is_mcf : s1_drop;
            mcf_lfc_valid <= frame_end && (opcode_q == mcf_op_lfc)
                             && (state == rx_params || state == rx_drop);
            if (rx_in_valid) begin
                case (state)
                    rx_hdr0: begin
                        if (!rx_in_last) state <= rx_hdr1;
                    end
                    rx_hdr1: begin
                        opcode_q <= in_opcode;
                        if (rx_in_last) state <= rx_hdr0;    // too short to carry quanta
                        else if (is_mcf) state <= rx_params;
                        else state <= rx_pass;
                    end
                    rx_params: begin
                        state <= rx_in_last ? rx_hdr0 : rx_drop;
                    end
                    default: begin
                        if (rx_in_last) state <= rx_hdr0;
                    end
                endcase
            end
        end
    end

    assign rx_out_valid = s2_valid && !s2_drop;
    assign rx_out_data  = s2_data;
    assign rx_out_keep  = s2_keep;
    assign rx_out_last  = s2_last;

endmodule

// ==== design/mac_pause_pkg.sv ====
// pause opcode, quanta and timer types used by the flow control blocks
`include "mac_lfc_params.svh"

package mac_pause_pkg;

    typedef enum logic [15:0] {
        mcf_op_other = 16'h0000,
        mcf_op_lfc   = 16'h0001     // annex 31B PAUSE
    } mcf_opcode_e;

    typedef logic [15:0] quanta_t;

    // integer quanta in the upper bits, sub-quantum fraction below
    typedef logic [$bits(quanta_t)+`QUANTA_FRAC_W-1:0] pause_timer_t;

    typedef enum logic [1:0] {
        ev_none,
        ev_xoff,
        ev_xon
    } lfc_event_e;

endpackage

// ==== design/mac_frame_pkg.sv ====
// stream beat, address and frame FSM state types shared by the rx filter and tx mux
`include "mac_lfc_params.svh"

package mac_frame_pkg;

    typedef logic [`MAC_DATA_W-1:0] data_t;     // byte 0 on bits 7:0
    typedef logic [`MAC_KEEP_W-1:0] keep_t;
    typedef logic [47:0]            mac_addr_t; // network order, first byte in msbs

    // beat position within the frame arriving at the rx filter
    typedef enum logic [2:0] {
        rx_hdr0,    // expecting dst and start of src
        rx_hdr1,    // expecting rest of src, ethertype, opcode
        rx_params,  // first params beat of a control frame
        rx_pass,    // rest of a forwarded frame
        rx_drop     // rest of a consumed control frame
    } rx_filt_state_e;

    typedef enum logic [2:0] {
        tx_idle,        // between frames, arbitration point
        tx_data,        // user frame passing through
        tx_mcf_hdr0,
        tx_mcf_hdr1,
        tx_mcf_params   // quanta beat, carries last
    } tx_mux_state_e;

endpackage

// ==== include/mac_lfc_params.svh ====
// widths, control frame fields and pause quanta timing, included by the packages and RTL
`ifndef MAC_LFC_PARAMS_SVH
`define MAC_LFC_PARAMS_SVH

// stream geometry
`define MAC_DATA_W      64
`define MAC_KEEP_W      8

`define MCF_DST_MCAST   48'h01_80_c2_00_00_01   // reserved PAUSE multicast
`define MCF_ETH_TYPE    16'h8808                // MAC control ethertype
`define LFC_SRC_ADDR    48'h02_00_5e_10_00_01   // locally administered station address

// one quantum is 512 bit times, 64 bits move per clock
`define QUANTA_FRAC_W   8
`define QUANTA_STEP     32                      // 256 * 64 / 512

`endif
